/* hdl/cachePkg.sv */
package cachePkg;

    // --------------------
    // Data path types
    // --------------------

    // One 32-bit data word, also used for byte addresses
    typedef logic [31:0] wordT;

    // Byte enables, bit n covers bits 8n+7..8n of a word
    typedef logic [3:0] byteMaskT;

    // All lanes enabled, used for whole-word refill writes
    localparam byteMaskT fullMask = 4'hF;

    // --------------------
    // Controller states
    // --------------------

    // Idle      waiting for req
    // Lookup    tags compared, write hits land here
    // WriteBack dirty victim block streamed out to memory
    // Refill    missing block streamed in from memory
    // Merge     write miss bytes merged into the fresh line
    // Done      ack held until req drops
    typedef enum logic [2:0] {
        Idle,
        Lookup,
        WriteBack,
        Refill,
        Merge,
        Done
    } ctrlStateT;

endpackage

/* hdl/cacheWay.sv */
module cacheWay #(
    parameter int blockWords = 4,
    parameter int lines = 2,
    localparam int setBits = $clog2(lines),
    localparam int offBits = $clog2(blockWords),
    localparam int tagBits = 30 - setBits - offBits
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [setBits-1:0]              set,
    input  logic [offBits-1:0]              wordOffset,
    input  logic                            we,
    input  logic                            markDirty,
    input  cachePkg::wordT                  wData,
    input  cachePkg::byteMaskT              mask,
    input  logic [tagBits-1:0]              tag,
    output logic                            valid,
    output logic                            dirty,
    output logic [tagBits-1:0]              rTag,
    output cachePkg::wordT [blockWords-1:0] block
);
    import cachePkg::*;

    // Per-set status bits
    logic [lines-1:0] validBits;
    logic [lines-1:0] dirtyBits;

    // Tag and data storage
    logic [tagBits-1:0] tagStore [lines];
    wordT [blockWords-1:0] dataStore [lines];

    // Old word with the enabled lanes replaced
    wordT mergedWord;

    // --------------------
    // Byte lane merge
    // --------------------
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                mergedWord[8*b +: 8] = wData[8*b +: 8];
            end else begin
                mergedWord[8*b +: 8] = dataStore[set][wordOffset][8*b +: 8];
            end
        end
    end

    // Valid and dirty bits clear on reset
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else if (we) begin
            validBits[set] <= 1'b1;
            // Processor writes mark dirty, refill words clear it
            dirtyBits[set] <= markDirty;
        end
    end

    // Tag follows every write so a refill claims the set
    always_ff @(posedge clk) begin
        if (we) begin
            tagStore[set] <= tag;
            dataStore[set][wordOffset] <= mergedWord;
        end
    end

    // Asynchronous read of the addressed set
    assign valid = validBits[set];
    assign dirty = dirtyBits[set];
    assign rTag  = tagStore[set];
    assign block = dataStore[set];

endmodule

/* hdl/cacheController.sv */
module cacheController (
    input  logic clk,
    input  logic reset,
    input  logic req,
    input  logic write,
    input  logic hit,
    input  logic victimDirty,
    input  logic lastWord,
    input  logic busReady,
    output logic cacheWe,
    output logic markDirty,
    output logic fillSel,
    output logic rdSel,
    output logic busReq,
    output logic busWrite,
    output logic counterClear,
    output logic ack
);
    import cachePkg::*;

    ctrlStateT state;
    ctrlStateT nextState;

    // Set once the lookup missed, held to the end of the access
    logic missed;

    // Final word of a block transfer accepted this cycle
    logic blockDone;

    assign blockDone = busReady & lastWord;

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (req) begin
                    nextState = Lookup;
                end
            end
            Lookup: begin
                // Clean victims skip straight to refill
                if (hit) begin
                    nextState = Done;
                end else if (victimDirty) begin
                    nextState = WriteBack;
                end else begin
                    nextState = Refill;
                end
            end
            WriteBack: begin
                if (blockDone) begin
                    nextState = Refill;
                end
            end
            Refill: begin
                if (blockDone) begin
                    nextState = write ? Merge : Done;
                end
            end
            Merge: nextState = Done;
            Done: begin
                if (!req) begin
                    nextState = Idle;
                end
            end
            default: nextState = Idle;
        endcase
    end

    // Miss flag and registered ack
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            missed <= 1'b0;
            ack    <= 1'b0;
        end else begin
            if (state == Idle) begin
                missed <= 1'b0;
            end else if (state == Lookup && !hit) begin
                missed <= 1'b1;
            end
            // One cycle in Done before ack, drops the cycle after req
            ack <= (state == Done) & req;
        end
    end

    // --------------------
    // Output decode
    // --------------------
    always_comb begin
        counterClear = (state == Lookup);
        busReq       = (state == WriteBack) || (state == Refill);
        busWrite     = (state == WriteBack);
        fillSel      = (state == Refill);
        // Read misses return the word caught off the bus
        rdSel        = (state == Done) & missed & ~write;
        case (state)
            Lookup:  cacheWe = hit & write;
            Refill:  cacheWe = busReady;
            Merge:   cacheWe = 1'b1;
            default: cacheWe = 1'b0;
        endcase
        markDirty = (state != Refill);
    end

endmodule

/* hdl/dataCache.sv */
module dataCache #(
    parameter int blockWords = 4,
    parameter int lines = 2,
    localparam int setBits = $clog2(lines),
    localparam int offBits = $clog2(blockWords),
    localparam int tagBits = 30 - setBits - offBits
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               req,
    input  logic               write,
    input  cachePkg::wordT     addr,
    input  cachePkg::wordT     wData,
    input  cachePkg::byteMaskT mask,
    input  cachePkg::wordT     busRData,
    input  logic               busReady,
    output logic               ack,
    output cachePkg::wordT     rData,
    output logic               hit,
    output logic               busReq,
    output logic               busWrite,
    output cachePkg::wordT     busAddr,
    output cachePkg::wordT     busWData
);
    import cachePkg::*;

    // Request address fields
    logic [tagBits-1:0] reqTag;
    logic [setBits-1:0] reqSet;
    logic [offBits-1:0] reqOffset;

    // Way status and outputs
    logic way0Valid, way1Valid, way0Dirty, way1Dirty;
    logic [tagBits-1:0] way0Tag, way1Tag, victimTag;
    wordT [blockWords-1:0] way0Block, way1Block;
    logic way0Hit, way1Hit, lookupHit;

    // Way choice, LRU table, controller strobes
    logic useWay1, way0We, way1We, victimDirty;
    logic [lines-1:0] mruWay1;
    logic cacheWe, markDirty, fillSel, rdSel, counterClear, lastWord;

    // Block transfer counter and way write path
    logic [offBits-1:0] wordCount, wayOffset;
    wordT wayData, hitWord, missWord;
    byteMaskT wayMask;

    assign reqTag    = addr[31 -: tagBits];
    assign reqSet    = addr[offBits+2 +: setBits];
    assign reqOffset = addr[2 +: offBits];

    // --------------------
    // Hit and way choice
    // --------------------
    assign way0Hit   = way0Valid & (way0Tag == reqTag);
    assign way1Hit   = way1Valid & (way1Tag == reqTag);
    assign lookupHit = way0Hit | way1Hit;

    // Hit way, then a free way, then the least recently used one
    always_comb begin
        if (way0Hit | way1Hit) begin
            useWay1 = way1Hit;
        end else if (!way0Valid) begin
            useWay1 = 1'b0;
        end else if (!way1Valid) begin
            useWay1 = 1'b1;
        end else begin
            useWay1 = ~mruWay1[reqSet];
        end
    end

    assign way0We      = cacheWe & ~useWay1;
    assign way1We      = cacheWe & useWay1;
    assign victimDirty = useWay1 ? (way1Valid & way1Dirty) : (way0Valid & way0Dirty);
    assign victimTag   = useWay1 ? way1Tag : way0Tag;

    // LRU follows hits as well as writes
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            mruWay1 <= '0;
        end else if (cacheWe | (counterClear & lookupHit)) begin
            mruWay1[reqSet] <= useWay1;
        end
    end

    // Block word counter, steps on each bus word
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            wordCount <= '0;
            hit       <= 1'b0;
        end else begin
            if (counterClear) begin
                wordCount <= '0;
                // Lookup result is what the processor sees
                hit <= lookupHit;
            end else if (busReq & busReady) begin
                wordCount <= wordCount + 1'b1;
            end
        end
    end

    assign lastWord = (wordCount == offBits'(blockWords - 1));

    // Requested word as it passes on the bus
    always_ff @(posedge clk) begin
        if (busReq & busReady & ~busWrite & (wordCount == reqOffset)) begin
            missWord <= busRData;
        end
    end

    // Way write path, bus words during refill
    assign wayOffset = fillSel ? wordCount : reqOffset;
    assign wayData   = fillSel ? busRData : wData;
    assign wayMask   = fillSel ? fullMask : mask;

    // --------------------
    // Bus side muxes
    // --------------------
    // Victim tag while writing back, request tag while refilling
    assign busAddr  = {(busWrite ? victimTag : reqTag), reqSet, wordCount, 2'b00};
    assign busWData = useWay1 ? way1Block[wordCount] : way0Block[wordCount];

    assign hitWord = way1Hit ? way1Block[reqOffset] : way0Block[reqOffset];
    assign rData   = rdSel ? missWord : hitWord;

    cacheWay #(.blockWords(blockWords), .lines(lines)) way0_i (
        .clk(clk), .reset(reset), .set(reqSet), .wordOffset(wayOffset),
        .we(way0We), .markDirty(markDirty), .wData(wayData), .mask(wayMask),
        .tag(reqTag), .valid(way0Valid), .dirty(way0Dirty), .rTag(way0Tag),
        .block(way0Block)
    );

    cacheWay #(.blockWords(blockWords), .lines(lines)) way1_i (
        .clk(clk), .reset(reset), .set(reqSet), .wordOffset(wayOffset),
        .we(way1We), .markDirty(markDirty), .wData(wayData), .mask(wayMask),
        .tag(reqTag), .valid(way1Valid), .dirty(way1Dirty), .rTag(way1Tag),
        .block(way1Block)
    );

    cacheController ctrl_i (
        .clk(clk), .reset(reset), .req(req), .write(write), .hit(lookupHit),
        .victimDirty(victimDirty), .lastWord(lastWord), .busReady(busReady),
        .cacheWe(cacheWe), .markDirty(markDirty), .fillSel(fillSel), .rdSel(rdSel),
        .busReq(busReq), .busWrite(busWrite), .counterClear(counterClear), .ack(ack)
    );

endmodule

/* hdl/busMemory.sv */
module busMemory #(
    parameter int memWords = 256,
    parameter int memLatency = 2,
    localparam int idxBits = $clog2(memWords),
    localparam int cntBits = (memLatency > 1) ? $clog2(memLatency) : 1
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           busReq,
    input  logic           busWrite,
    input  cachePkg::wordT busAddr,
    input  cachePkg::wordT busWData,
    output cachePkg::wordT busRData,
    output logic           busReady
);
    import cachePkg::*;

    // Word array, reloaded on reset
    wordT mem [memWords];

    // Cycles spent on the current word
    logic [cntBits-1:0] latencyCount;

    // Word index from the byte address
    logic [idxBits-1:0] memIndex;

    assign memIndex = busAddr[idxBits+1:2];

    // --------------------
    // Latency pacing
    // --------------------
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            latencyCount <= '0;
        end else if (!busReq) begin
            latencyCount <= '0;
        end else if (busReady) begin
            latencyCount <= '0;
        end else begin
            latencyCount <= latencyCount + 1'b1;
        end
    end

    // One pulse per memLatency cycles of busReq
    assign busReady = busReq & (latencyCount == cntBits'(memLatency - 1));

    // Word n holds the inverse of its byte address after reset
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            for (int n = 0; n < memWords; n++) begin
                mem[n] <= ~wordT'(n * 4);
            end
        end else if (busReady & busWrite) begin
            mem[memIndex] <= busWData;
        end
    end

    // Read data valid on the busReady cycle
    assign busRData = mem[memIndex];

endmodule

/* hdl/cacheTop.sv */
module cacheTop #(
    parameter int blockWords = 4,
    parameter int lines = 2,
    parameter int memLatency = 2,
    parameter int memWords = 256
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               req,
    input  logic               write,
    input  cachePkg::wordT     addr,
    input  cachePkg::wordT     wData,
    input  cachePkg::byteMaskT mask,
    output logic               ack,
    output cachePkg::wordT     rData,
    output logic               hit
);
    import cachePkg::*;

    // --------------------
    // Word bus
    // --------------------
    logic busReq, busWrite, busReady;
    wordT busAddr, busWData, busRData;

    dataCache #(.blockWords(blockWords), .lines(lines)) cache_i (
        .clk(clk), .reset(reset),
        .req(req), .write(write), .addr(addr), .wData(wData), .mask(mask),
        .busRData(busRData), .busReady(busReady),
        .ack(ack), .rData(rData), .hit(hit),
        .busReq(busReq), .busWrite(busWrite), .busAddr(busAddr), .busWData(busWData)
    );

    // Backing store behind the cache
    busMemory #(.memWords(memWords), .memLatency(memLatency)) mem_i (
        .clk(clk), .reset(reset),
        .busReq(busReq), .busWrite(busWrite), .busAddr(busAddr), .busWData(busWData),
        .busRData(busRData), .busReady(busReady)
    );

endmodule

/* tests/cacheHandshake_asserts.sv */
module cacheHandshake_asserts (
    input logic           clk,
    input logic           reset,
    input logic           req,
    input logic           ack,
    input logic           busReq,
    input logic           busWrite,
    input logic           busReady,
    input cachePkg::wordT busAddr
);
    timeunit 1ns;
    timeprecision 100ps;
    import cachePkg::*;

    // --------------------
    // Processor side
    // --------------------
    // No ack without a request behind it
    ackNeedsReq: assert property (@(posedge clk) disable iff (reset) !req |=> !ack)
        else $error("ack raised while req was low");

    // ack held until req drops
    ackHeld: assert property (@(posedge clk) disable iff (reset) ack && req |=> ack)
        else $error("ack dropped while req was still high");

    // --------------------
    // Word bus
    // --------------------
    // Request, direction and address frozen between busReady pulses
    busHeld: assert property (@(posedge clk) disable iff (reset)
        busReq && !busReady |=> busReq && $stable(busWrite) && $stable(busAddr))
        else $error("bus transfer changed before busReady");

    // Both sides quiet in reset
    quietInReset: assert property (@(posedge clk) reset |-> !ack && !busReq)
        else $error("ack or busReq high during reset");

endmodule

/* tests/cacheTb.sv */
module cacheTb;
    timeunit 1ns;
    timeprecision 100ps;
    import cachePkg::*;

    localparam int blockWords = 4;
    localparam int lines = 2;
    localparam int memLatency = 2;
    localparam int memWords = 256;
    localparam int resetCycles = 16;
    // Worst dirty miss plus handshake, idle gap and margin
    localparam int cyclesPerEntry = 4 * blockWords * memLatency + 20;

    logic clk;
    logic reset;
    logic req;
    logic write;
    wordT addr;
    wordT wData;
    byteMaskT mask;
    logic ack;
    wordT rData;
    logic hit;

    // Access list from the data file
    logic     entryWrite [$];
    wordT     entryAddr [$];
    wordT     entryWData [$];
    byteMaskT entryMask [$];
    wordT     entryData [$];
    logic     entryHit [$];

    int cycleCount;
    int cycleLimit;

    cacheTop #(
        .blockWords(blockWords),
        .lines(lines),
        .memLatency(memLatency),
        .memWords(memWords)
    ) dut_i (
        .clk(clk), .reset(reset),
        .req(req), .write(write), .addr(addr), .wData(wData), .mask(mask),
        .ack(ack), .rData(rData), .hit(hit)
    );

    // Protocol checks inside the cache
    bind dataCache cacheHandshake_asserts asserts_i (
        .clk(clk), .reset(reset), .req(req), .ack(ack),
        .busReq(busReq), .busWrite(busWrite), .busReady(busReady), .busAddr(busAddr)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // --------------------
    // Error handling
    // --------------------
    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkWord(input string what, input wordT actual, input wordT expected);
        if (actual !== expected) begin
            stopOnError($sformatf("mismatch at %0d ns: %s expected %08h, got %08h",
                $time, what, expected, actual));
        end
    endtask

    task automatic checkFlag(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            stopOnError($sformatf("mismatch at %0d ns: %s expected %b, got %b",
                $time, what, expected, actual));
        end
    endtask

    // Run limit from the number of accesses
    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            stopOnError($sformatf("run timed out after %0d cycles", cycleCount));
        end
    end

    // --------------------
    // Stimulus file
    // --------------------
    task automatic loadEntries();
        int fd;
        int fields;
        string line;
        logic [7:0] opChar;
        wordT a;
        wordT d;
        byteMaskT m;
        wordT e;
        logic h;
        fd = $fopen("tests/cacheInput.txt", "r");
        if (fd == 0) begin
            stopOnError("could not open tests/cacheInput.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%s %h %h %h %h %h", opChar, a, d, m, e, h);
                // Comment lines start with a hash
                if (line.len() > 0 && line.getc(0) == "#") begin
                    fields = 0;
                end else if (fields == 6) begin
                    entryWrite.push_back(opChar == "W");
                    entryAddr.push_back(a);
                    entryWData.push_back(d);
                    entryMask.push_back(m);
                    entryData.push_back(e);
                    entryHit.push_back(h);
                end else if (fields > 0) begin
                    stopOnError({"malformed line in stimulus file: ", line});
                end
            end
            $fclose(fd);
        end
    endtask

    // One four-phase access checked at ack
    task automatic runAccess(input int idx);
        int latency;
        logic latencyHit;
        string what;
        what = $sformatf("entry %0d %s %08h", idx,
            entryWrite[idx] ? "write" : "read", entryAddr[idx]);
        @(posedge clk);
        #1;
        req   = 1'b1;
        write = entryWrite[idx];
        addr  = entryAddr[idx];
        wData = entryWData[idx];
        mask  = entryMask[idx];
        // Edge that samples req
        @(posedge clk);
        latency = 0;
        do begin
            @(posedge clk);
            #1;
            latency++;
        end while (!ack);
        // Hits answer exactly two cycles after req is sampled
        latencyHit = (latency == 2);
        checkWord({what, " rData"}, rData, entryData[idx]);
        checkFlag({what, " hit"}, hit, entryHit[idx]);
        checkFlag({what, " hit by ack latency"}, latencyHit, entryHit[idx]);
        req = 1'b0;
        while (ack) begin
            @(posedge clk);
            #1;
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int gap;
        clk        = 1'b0;
        reset      = 1'b1;
        req        = 1'b0;
        write      = 1'b0;
        addr       = '0;
        wData      = '0;
        mask       = '0;
        cycleCount = 0;
        cycleLimit = 0;
        void'($urandom(32'hc062));
        loadEntries();
        if (entryAddr.size() == 0) begin
            stopOnError("stimulus file holds no accesses");
        end
        cycleLimit = entryAddr.size() * cyclesPerEntry + resetCycles;

        // ack quiet through reset
        repeat (resetCycles) begin
            @(posedge clk);
            #1;
            checkFlag("ack during reset", ack, 1'b0);
        end
        reset = 1'b0;
        // and quiet until the first req
        repeat (2) begin
            @(posedge clk);
            #1;
            checkFlag("ack before first request", ack, 1'b0);
        end

        foreach (entryAddr[i]) begin
            runAccess(i);
            // Random idle gap between accesses
            gap = $urandom_range(3, 0);
            repeat (gap) @(posedge clk);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* tests/cacheInput.txt */
# op addr wData mask expected-rData expected-hit, all hex
# op R reads, W writes; reads carry zero data and mask
# read miss after reset, then hits and byte merges in set 0
R 00000000 00000000 0 FFFFFFFF 0
R 00000004 00000000 0 FFFFFFFB 1
W 00000008 A5A5A5A5 3 FFFFA5A5 1
R 00000008 00000000 0 FFFFA5A5 1
W 0000000C 12345678 C 1234FFF3 1
# write-allocate in set 1
W 00000030 000000AB 1 FFFFFFAB 0
R 00000034 00000000 0 FFFFFFCB 1
R 0000003C 00000000 0 FFFFFFC3 1
R 00000030 00000000 0 FFFFFFAB 1
# LRU in set 0 with A 000, B 020, C 040
R 00000020 00000000 0 FFFFFFDF 0
R 00000000 00000000 0 FFFFFFFF 1
R 00000044 00000000 0 FFFFFFBB 0
R 00000008 00000000 0 FFFFA5A5 1
R 00000020 00000000 0 FFFFFFDF 0
# dirty A evicted, then read back from memory
R 00000060 00000000 0 FFFFFF9F 0
R 00000008 00000000 0 FFFFA5A5 0
R 0000000C 00000000 0 1234FFF3 1
R 00000000 00000000 0 FFFFFFFF 1
# set 1 write misses and writebacks
R 00000010 00000000 0 FFFFFFEF 0
W 00000050 DEADBEEF F DEADBEEF 0
R 00000030 00000000 0 FFFFFFAB 0
R 00000058 00000000 0 FFFFFFA7 1
R 00000050 00000000 0 DEADBEEF 1
W 00000034 00CC3300 6 FFCC33CB 1
R 00000034 00000000 0 FFCC33CB 1
R 00000070 00000000 0 FFFFFF8F 0
R 00000050 00000000 0 DEADBEEF 0
R 00000034 00000000 0 FFCC33CB 0
R 0000005C 00000000 0 FFFFFFA3 1
# high address and an empty mask
R 000003F0 00000000 0 FFFFFC0F 0
R 000003FC 00000000 0 FFFFFC03 1
W 00000050 11111111 0 DEADBEEF 1

/* vlog.f */
hdl/cachePkg.sv
hdl/cacheWay.sv
hdl/cacheController.sv
hdl/dataCache.sv
hdl/busMemory.sv
hdl/cacheTop.sv
tests/cacheHandshake_asserts.sv
tests/cacheTb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := cacheTb
FILELIST   := vlog.f
COMMON     := --timing --assert --timescale 1ns/100ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary $(COMMON)
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
